// ==== src.f ====
source/tcp_tx_pkg.sv
source/tcp_tx_ctl.sv
source/tcp_tx_arb.sv
source/tcp_hdr_emit.sv
source/tcp_tx_top.sv
dv/tcp_tx_tb.sv

// ==== Makefile ====
# Verilator build and run for the TCP transmit header path

VERILATOR ?= verilator
TOP       ?= tcp_tx_tb
RTL_TOP   ?= tcp_tx_top
FILELIST  ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard source/*.sv dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD)/$(TOP)

$(BUILD)/$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)

run: build
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/tcp_tx_tb.sv ====
`timescale 1ns/1ps

module tcp_tx_tb
  import tcp_tx_pkg::*;
();

  localparam int       CLK_PERIOD = 8;
  localparam int       SEG_CYCLES = 100;  // generous bound for one header, back-pressure included
  localparam int       RUN_CYCLES = 2 * (16 + 16 * SEG_CYCLES + KA_TIMEOUT);
  localparam tcp_num_t INIT_SEQ   = 32'h1000_0ff0;

  logic        clk;
  logic        rst;
  tcb_t        tcb;
  ipv4_addr_t  src_ip;
  tcp_stat_t   status;
  tcp_num_t    init_seq;
  logic        pld_valid;
  logic [15:0] pld_len_in;
  logic [15:0] pld_cks_in;
  logic        ack_req;
  logic        eng_rdy;
  tcp_meta_t   eng_meta;
  logic        hdr_ready;
  logic        pld_ready;
  logic        eng_acc;
  logic        eng_done;
  logic [31:0] hdr_data;
  logic        hdr_valid;
  logic        hdr_last;

  integer       seed = 32'h25fa_36f3;
  bit           bp_en = 1'b0;
  int           err_cnt = 0;
  int           chk_cnt = 0;
  int           test_cnt = 0;
  int           cyc = 0;
  int           word_cnt = 0;
  int           word_total = 0;
  int           hdr_cnt = 0;
  int           last_cnt = 0;
  int           stall_cnt = 0;
  int           eng_acc_cnt = 0;
  int           eng_done_cnt = 0;
  logic [319:0] cur_hdr;
  logic [319:0] hdr_q[$];

  // reference model state
  tcp_num_t    m_loc_seq;
  tcp_num_t    m_last_seq;
  logic [15:0] m_id;

  tcp_tx_top dut (
    .clk, .rst, .tcb, .src_ip, .status, .init_seq, .pld_valid, .pld_len_in, .pld_cks_in,
    .ack_req, .eng_rdy, .eng_meta, .hdr_ready, .pld_ready, .eng_acc, .eng_done,
    .hdr_data, .hdr_valid, .hdr_last
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc       <= cyc + 1;
    hdr_ready <= bp_en ? (($random(seed) & 3) != 0) : 1'b1;  // ~75% ready
    if (eng_acc) eng_acc_cnt <= eng_acc_cnt + 1;
    if (eng_done) eng_done_cnt <= eng_done_cnt + 1;
    if (hdr_valid && !hdr_ready) stall_cnt <= stall_cnt + 1;
  end

  // header collector, word 0 lands in the msbs
  always @(posedge clk) begin
    if (hdr_valid && hdr_ready) begin
      check_val("hdr_last position", 64'(hdr_last), 64'(word_cnt == HDR_WORDS - 1));
      cur_hdr[(HDR_WORDS - 1 - word_cnt) * 32 +: 32] = hdr_data;
      word_total <= word_total + 1;
      if (hdr_last) last_cnt <= last_cnt + 1;
      if (word_cnt == HDR_WORDS - 1) begin
        hdr_q.push_back(cur_hdr);
        hdr_cnt  <= hdr_cnt + 1;
        word_cnt <= 0;
      end else begin
        word_cnt <= word_cnt + 1;
      end
    end
  end

  task automatic check_val(string what, logic [63:0] got, logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // ones-complement sum of ten halfwords, cks field as zero
  function automatic logic [15:0] ip_cks(ipv4_hdr_t ip);
    logic [31:0] acc;
    ip.cks = '0;
    acc    = '0;
    for (int i = 0; i < 10; i++) begin
      acc = acc + 32'(ip[159 - 16 * i -: 16]);
    end
    while (acc[31:16] != 0) begin
      acc = 32'(acc[15:0]) + 32'(acc[31:16]);
    end
    return ~acc[15:0];
  endfunction

  function automatic logic [319:0] local_hdr(tx_type_t kind, logic [15:0] len, tcp_num_t seq);
    ipv4_hdr_t ip;
    tcp_hdr_t  tcp;
    ip               = '0;
    tcp              = '0;
    ip.ver           = 4'd4;
    ip.ihl           = 4'd5;
    ip.length        = (kind == tx_pld) ? len + 16'd40 : 16'd40;
    ip.id            = m_id;
    ip.df            = 1'b1;
    ip.ttl           = 8'd64;
    ip.proto         = 8'd6;
    ip.src_ip        = src_ip;
    ip.dst_ip        = tcb.ipv4_addr;
    ip.cks           = ip_cks(ip);
    tcp.src_port     = tcb.loc_port;
    tcp.dst_port     = tcb.rem_port;
    tcp.tcp_seq_num  = seq;
    tcp.tcp_ack_num  = tcb.loc_ack;
    tcp.tcp_offset   = 4'd5;
    tcp.tcp_flags    = (kind == tx_pld) ? 9'h018 : 9'h010;  // psh+ack or ack
    tcp.tcp_wnd_size = 16'd1000;
    return {ip, tcp};
  endfunction

  task automatic get_header(input int max_cycles, output logic [319:0] h, output bit ok);
    int n;
    n = 0;
    while (hdr_q.size() == 0 && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    ok = hdr_q.size() != 0;
    h  = ok ? hdr_q.pop_front() : '0;
    if (!ok) begin
      $display("no header arrived within %0d cycles at %0t", max_cycles, $time);
      err_cnt++;
    end
  endtask

  task automatic compare_hdr(string name, logic [319:0] got, logic [319:0] exp);
    for (int i = 0; i < HDR_WORDS; i++) begin
      check_val($sformatf("%s word %0d", name, i), 64'(got[(HDR_WORDS - 1 - i) * 32 +: 32]),
                64'(exp[(HDR_WORDS - 1 - i) * 32 +: 32]));
    end
  endtask

  task automatic expect_segment(string name, tx_type_t kind, logic [15:0] len, int max_cycles);
    tcp_num_t     seq;
    logic [319:0] got;
    logic [319:0] exp;
    bit           ok;
    m_id = m_id + 16'd1;
    case (kind)
      tx_pld:  seq = m_loc_seq;
      tx_ka:   seq = m_last_seq - 32'd1;
      default: seq = m_last_seq;
    endcase
    exp = local_hdr(kind, len, seq);
    get_header(max_cycles, got, ok);
    if (ok) compare_hdr(name, got, exp);
    if (kind == tx_pld) begin
      m_loc_seq  = m_loc_seq + 32'(len);
      m_last_seq = m_loc_seq;
    end
  endtask

  task automatic offer_payload(logic [15:0] len, logic [15:0] cks, bit with_ack);
    @(posedge clk);
    while (!pld_ready) @(posedge clk);
    pld_valid  <= 1'b1;
    pld_len_in <= len;
    pld_cks_in <= cks;
    ack_req    <= with_ack;
    @(posedge clk);
    pld_valid <= 1'b0;
    ack_req   <= 1'b0;
  endtask

  task automatic request_ack();
    @(posedge clk);
    ack_req <= 1'b1;
    @(posedge clk);
    ack_req <= 1'b0;
  endtask

  task automatic report_test(string name, int err_before);
    test_cnt++;
    if (err_cnt == err_before)
      $display("test %-14s ok", name);
    else
      $display("test %-14s failed with %0d errors", name, err_cnt - err_before);
  endtask

  task automatic test_payload();
    int err0;
    err0 = err_cnt;
    offer_payload(16'd100, 16'h1234, 1'b0);
    expect_segment("payload 1", tx_pld, 16'd100, SEG_CYCLES);
    offer_payload(16'd37, 16'h0f0f, 1'b0);
    expect_segment("payload 2", tx_pld, 16'd37, SEG_CYCLES);
    report_test("payload", err0);
  endtask

  task automatic test_forced_ack();
    int err0;
    err0 = err_cnt;
    request_ack();
    expect_segment("ack", tx_ack, 16'd0, SEG_CYCLES);
    offer_payload(16'd512, 16'hbeef, 1'b1);  // both pending together
    expect_segment("pld before ack", tx_pld, 16'd512, SEG_CYCLES);
    expect_segment("ack after pld", tx_ack, 16'd0, SEG_CYCLES);
    report_test("forced ack", err0);
  endtask

  task automatic test_keepalive();
    int err0;
    int start;
    err0  = err_cnt;
    start = cyc;
    expect_segment("keep-alive", tx_ka, 16'd0, KA_TIMEOUT + SEG_CYCLES);
    check_val("keep-alive not early", 64'(cyc - start >= KA_TIMEOUT), 64'd1);
    report_test("keep-alive", err0);
  endtask

  task automatic test_id_last();
    int err0;
    int hdrs0;
    int last0;
    err0  = err_cnt;
    hdrs0 = hdr_cnt;
    last0 = last_cnt;
    repeat (3) begin
      request_ack();
      expect_segment("ack burst", tx_ack, 16'd0, SEG_CYCLES);
    end
    @(posedge clk);
    check_val("headers in burst", 64'(hdr_cnt - hdrs0), 64'd3);
    check_val("hdr_last count", 64'(last_cnt - last0), 64'(hdr_cnt - hdrs0));
    report_test("id and last", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    int stall0;
    err0   = err_cnt;
    stall0 = stall_cnt;
    bp_en <= 1'b1;
    offer_payload(16'd1460, 16'h5555, 1'b0);
    expect_segment("bp payload", tx_pld, 16'd1460, SEG_CYCLES);
    request_ack();
    expect_segment("bp ack", tx_ack, 16'd0, SEG_CYCLES);
    bp_en <= 1'b0;
    check_val("stalls under back-pressure", 64'(stall_cnt > stall0), 64'd1);
    report_test("back-pressure", err0);
  endtask

  task automatic test_engine();
    int           err0;
    int           acc0;
    int           done0;
    int           words0;
    int           n;
    tcp_meta_t    em;
    ipv4_hdr_t    exp_ip;
    logic [319:0] got;
    bit           ok;
    err0                 = err_cnt;
    acc0                 = eng_acc_cnt;
    done0                = eng_done_cnt;
    em                   = '0;
    em.ipv4_hdr.ver      = 4'd4;
    em.ipv4_hdr.ihl      = 4'd5;
    em.ipv4_hdr.length   = 16'd40;
    em.ipv4_hdr.id       = 16'h4242;
    em.ipv4_hdr.df       = 1'b1;
    em.ipv4_hdr.ttl      = 8'd128;
    em.ipv4_hdr.proto    = 8'd6;
    em.ipv4_hdr.cks      = 16'hdead;  // must be replaced
    em.ipv4_hdr.src_ip   = src_ip;
    em.ipv4_hdr.dst_ip   = tcb.ipv4_addr;
    em.tcp_hdr.src_port  = tcb.loc_port;
    em.tcp_hdr.dst_port  = tcb.rem_port;
    em.tcp_hdr.tcp_seq_num  = INIT_SEQ - 32'd1;
    em.tcp_hdr.tcp_offset   = 4'd5;
    em.tcp_hdr.tcp_flags    = 9'h002;  // syn
    em.tcp_hdr.tcp_wnd_size = 16'hffff;
    repeat (3) @(posedge clk);  // last local segment still in its sent phase
    status <= tcp_closed;
    offer_payload(16'd64, 16'h7777, 1'b0);  // held until connected
    eng_meta <= em;
    eng_rdy  <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!eng_acc && n < SEG_CYCLES);
    eng_rdy <= 1'b0;
    exp_ip     = em.ipv4_hdr;
    exp_ip.cks = ip_cks(em.ipv4_hdr);
    get_header(SEG_CYCLES, got, ok);
    if (ok) compare_hdr("engine", got, {exp_ip, em.tcp_hdr});
    words0 = word_total;
    repeat (50) @(posedge clk);
    check_val("words while closed", 64'(word_total), 64'(words0));
    check_val("eng_acc pulses", 64'(eng_acc_cnt - acc0), 64'd1);
    check_val("eng_done pulses", 64'(eng_done_cnt - done0), 64'd1);
    check_val("pld_ready with payload held", 64'(pld_ready), 64'd0);
    status <= tcp_connected;
    expect_segment("held payload", tx_pld, 16'd64, SEG_CYCLES);
    repeat (3) @(posedge clk);
    check_val("pld_ready after payload sent", 64'(pld_ready), 64'd1);
    report_test("engine", err0);
  endtask

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish", RUN_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    tcb.loc_port  = 16'd5001;
    tcb.rem_port  = 16'd80;
    tcb.ipv4_addr = {8'd192, 8'd168, 8'd1, 8'd20};
    tcb.loc_ack   = 32'h0bad_f00d;
    src_ip        = {8'd192, 8'd168, 8'd1, 8'd10};
    status        = tcp_connected;
    init_seq      = INIT_SEQ;
    pld_valid     = 1'b0;
    pld_len_in    = '0;
    pld_cks_in    = '0;
    ack_req       = 1'b0;
    eng_rdy       = 1'b0;
    eng_meta      = '0;
    hdr_ready     = 1'b1;
    m_loc_seq     = INIT_SEQ;
    m_last_seq    = INIT_SEQ;
    m_id          = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_payload();
    test_forced_ack();
    test_keepalive();
    test_id_last();
    test_backpressure();
    test_engine();
    repeat (5) @(posedge clk);
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== source/tcp_tx_top.sv ====
`timescale 1ns/1ps

module tcp_tx_top
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  tcb_t        tcb,
  input  ipv4_addr_t  src_ip,
  input  tcp_stat_t   status,
  input  tcp_num_t    init_seq,
  input  logic        pld_valid,
  input  logic [15:0] pld_len_in,
  input  logic [15:0] pld_cks_in,
  input  logic        ack_req,
  input  logic        eng_rdy,
  input  tcp_meta_t   eng_meta,
  input  logic        hdr_ready,
  output logic        pld_ready,
  output logic        eng_acc,
  output logic        eng_done,
  output logic [31:0] hdr_data,
  output logic        hdr_valid,
  output logic        hdr_last
);

  logic        send_pld;
  logic        send_ka;
  logic        send_ack;
  logic        pld_sent;
  logic        ka_sent;
  logic        ack_sent;
  tcp_num_t    pld_seq;
  tcp_num_t    last_seq;
  logic [15:0] pld_len;
  logic [15:0] pld_cks;
  logic        seg_rdy;
  logic        seg_acc;
  logic        seg_done;
  tcp_meta_t   seg_meta;

  tcp_tx_ctl u_ctl (
    .clk, .rst, .init_seq, .pld_valid, .pld_len_in, .pld_cks_in, .ack_req, .status,
    .pld_sent, .ka_sent, .ack_sent, .pld_ready, .send_pld, .send_ka, .send_ack,
    .pld_seq, .pld_len, .pld_cks, .last_seq
  );

  tcp_tx_arb u_arb (
    .clk, .rst, .tcb, .src_ip, .status, .send_pld, .send_ka, .send_ack,
    .pld_seq, .pld_len, .pld_cks, .last_seq, .eng_rdy, .eng_meta, .seg_acc, .seg_done,
    .pld_sent, .ka_sent, .ack_sent, .eng_acc, .eng_done, .seg_rdy, .seg_meta
  );

  tcp_hdr_emit u_emit (
    .clk, .rst, .seg_rdy, .seg_meta, .hdr_ready,
    .seg_acc, .seg_done, .hdr_data, .hdr_valid, .hdr_last
  );

endmodule

// ==== source/tcp_hdr_emit.sv ====
`timescale 1ns/1ps

module tcp_hdr_emit
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        seg_rdy,
  input  tcp_meta_t   seg_meta,
  input  logic        hdr_ready,
  output logic        seg_acc,
  output logic        seg_done,
  output logic [31:0] hdr_data,
  output logic        hdr_valid,
  output logic        hdr_last
);

  typedef enum logic [1:0] {e_idle, e_cks, e_emit} emit_state_t;

  emit_state_t  state;
  ipv4_hdr_t    ip_r;
  tcp_hdr_t     tcp_r;
  ipv4_hdr_t    ip_z;
  logic [19:0]  sum;
  logic [15:0]  cks_calc;
  logic [3:0]   cnt;
  logic [319:0] hdr_bits;

  // ones-complement sum over the ten halfwords, cks taken as zero
  always_comb begin
    ip_z     = ip_r;
    ip_z.cks = '0;
    sum      = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + 20'(ip_z[i*16 +: 16]);
    end
    sum      = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum      = 20'(sum[15:0]) + 20'(sum[19:16]);  // second fold for the carry
    cks_calc = ~sum[15:0];
  end

  assign hdr_bits = {ip_r, tcp_r};
  assign hdr_data = hdr_bits[(HDR_WORDS - cnt) * 32 - 1 -: 32];  // word 0 is the msbs

  always_ff @(posedge clk) begin
    if (state == e_idle && seg_rdy) begin
      ip_r  <= seg_meta.ipv4_hdr;
      tcp_r <= seg_meta.tcp_hdr;
    end else if (state == e_cks) begin
      ip_r.cks <= cks_calc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= e_idle;
      seg_acc   <= 1'b0;
      seg_done  <= 1'b0;
      hdr_valid <= 1'b0;
      hdr_last  <= 1'b0;
      cnt       <= '0;
    end else begin
      seg_acc  <= 1'b0;
      seg_done <= 1'b0;
      case (state)
        e_idle: if (seg_rdy) begin
          seg_acc <= 1'b1;
          state   <= e_cks;
        end
        e_cks: begin
          hdr_valid <= 1'b1;
          cnt       <= '0;
          state     <= e_emit;
        end
        default: if (hdr_ready) begin
          if (cnt == 4'(HDR_WORDS - 1)) begin
            hdr_valid <= 1'b0;
            hdr_last  <= 1'b0;
            seg_done  <= 1'b1;
            state     <= e_idle;
          end else begin
            cnt      <= cnt + 1'b1;
            hdr_last <= (cnt == 4'(HDR_WORDS - 2));
          end
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr_data))
    else $error("header word changed under back-pressure");

endmodule

// ==== source/tcp_tx_arb.sv ====
`timescale 1ns/1ps

module tcp_tx_arb
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  tcb_t        tcb,
  input  ipv4_addr_t  src_ip,
  input  tcp_stat_t   status,
  input  logic        send_pld,
  input  logic        send_ka,
  input  logic        send_ack,
  input  tcp_num_t    pld_seq,
  input  logic [15:0] pld_len,
  input  logic [15:0] pld_cks,
  input  tcp_num_t    last_seq,
  input  logic        eng_rdy,
  input  tcp_meta_t   eng_meta,
  input  logic        seg_acc,
  input  logic        seg_done,
  output logic        pld_sent,
  output logic        ka_sent,
  output logic        ack_sent,
  output logic        eng_acc,
  output logic        eng_done,
  output logic        seg_rdy,
  output tcp_meta_t   seg_meta
);

  typedef enum logic [1:0] {idle_s, active_s, sent_s} arb_state_t;

  arb_state_t fsm;
  tx_type_t   tx_type;
  logic       rdy_arb;
  logic       acc_arb;
  logic       done_arb;
  tcp_meta_t  meta_arb;

  // engine owns the emitter unless the connection is up
  always_comb begin
    if (status == tcp_connected) begin
      seg_rdy  = rdy_arb;
      seg_meta = meta_arb;
      eng_acc  = 1'b0;
      eng_done = 1'b0;
      acc_arb  = seg_acc;
      done_arb = seg_done;
    end else begin
      seg_rdy  = eng_rdy;
      seg_meta = eng_meta;
      eng_acc  = seg_acc;
      eng_done = seg_done;
      acc_arb  = 1'b0;
      done_arb = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm                  <= idle_s;
      tx_type              <= tx_none;
      rdy_arb              <= 1'b0;
      pld_sent             <= 1'b0;
      ka_sent              <= 1'b0;
      ack_sent             <= 1'b0;
      meta_arb.ipv4_hdr.id <= '0;
    end else begin
      pld_sent <= 1'b0;
      ka_sent  <= 1'b0;
      ack_sent <= 1'b0;
      case (fsm)
        idle_s: begin
          meta_arb.tcp_hdr.tcp_offset   <= TCP_DEFAULT_OFFSET;
          meta_arb.tcp_hdr.reserved     <= '0;
          meta_arb.tcp_hdr.src_port     <= tcb.loc_port;
          meta_arb.tcp_hdr.dst_port     <= tcb.rem_port;
          meta_arb.tcp_hdr.tcp_wnd_size <= DEFAULT_WINDOW_SIZE;
          meta_arb.tcp_hdr.tcp_ack_num  <= tcb.loc_ack;
          meta_arb.tcp_hdr.tcp_cks      <= '0;
          meta_arb.tcp_hdr.tcp_pointer  <= '0;
          meta_arb.ipv4_hdr.ver         <= 4'd4;
          meta_arb.ipv4_hdr.ihl         <= 4'd5;
          meta_arb.ipv4_hdr.qos         <= '0;
          meta_arb.ipv4_hdr.zero        <= 1'b0;
          meta_arb.ipv4_hdr.df          <= 1'b1;
          meta_arb.ipv4_hdr.mf          <= 1'b0;
          meta_arb.ipv4_hdr.fo          <= '0;
          meta_arb.ipv4_hdr.ttl         <= DEFAULT_TTL;
          meta_arb.ipv4_hdr.proto       <= PROTO_TCP;
          meta_arb.ipv4_hdr.cks         <= '0;  // filled in by the emitter
          meta_arb.ipv4_hdr.src_ip      <= src_ip;
          meta_arb.ipv4_hdr.dst_ip      <= tcb.ipv4_addr;
          if (status == tcp_connected && (send_pld || send_ka || send_ack)) begin
            fsm                  <= active_s;
            rdy_arb              <= 1'b1;
            meta_arb.ipv4_hdr.id <= meta_arb.ipv4_hdr.id + 1'b1;
            if (send_pld) begin
              tx_type                      <= tx_pld;
              meta_arb.tcp_hdr.tcp_flags   <= TCP_FLAG_PSH | TCP_FLAG_ACK;
              meta_arb.tcp_hdr.tcp_seq_num <= pld_seq;
              meta_arb.ipv4_hdr.length     <= pld_len + 16'd40;
              meta_arb.pld_len             <= pld_len;
              meta_arb.pld_cks             <= pld_cks;
            end else begin
              tx_type                      <= send_ka ? tx_ka : tx_ack;
              meta_arb.tcp_hdr.tcp_flags   <= TCP_FLAG_ACK;
              // keep-alive probes one byte behind the last acked data
              meta_arb.tcp_hdr.tcp_seq_num <= send_ka ? last_seq - 32'd1 : last_seq;
              meta_arb.ipv4_hdr.length     <= 16'd40;
              meta_arb.pld_len             <= '0;
              meta_arb.pld_cks             <= '0;
            end
          end
        end
        active_s: begin
          if (acc_arb) rdy_arb <= 1'b0;
          if (done_arb) begin
            case (tx_type)
              tx_pld:  pld_sent <= 1'b1;
              tx_ka:   ka_sent  <= 1'b1;
              tx_ack:  ack_sent <= 1'b1;
              default: ;
            endcase
            tx_type <= tx_none;
            fsm     <= sent_s;
          end
        end
        default: fsm <= idle_s;  // sent_s, lets the request drop
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    seg_rdy && !seg_acc |=> $stable(seg_meta))
    else $error("segment metadata changed before accept");

endmodule

// ==== source/tcp_tx_ctl.sv ====
`timescale 1ns/1ps

module tcp_tx_ctl
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  tcp_num_t    init_seq,
  input  logic        pld_valid,
  input  logic [15:0] pld_len_in,
  input  logic [15:0] pld_cks_in,
  input  logic        ack_req,
  input  tcp_stat_t   status,
  input  logic        pld_sent,
  input  logic        ka_sent,
  input  logic        ack_sent,
  output logic        pld_ready,
  output logic        send_pld,
  output logic        send_ka,
  output logic        send_ack,
  output tcp_num_t    pld_seq,
  output logic [15:0] pld_len,
  output logic [15:0] pld_cks,
  output tcp_num_t    last_seq
);

  tcp_num_t            loc_seq;
  logic [KA_CNT_W-1:0] ka_cnt;
  logic                tx_idle;

  assign pld_ready = !send_pld;  // one payload held at a time
  assign pld_seq   = loc_seq;

  assign tx_idle = (status == tcp_connected) && !send_pld && !send_ka && !send_ack &&
                   !pld_sent && !ka_sent && !ack_sent;

  // payload length and checksum only matter while send_pld is high
  always_ff @(posedge clk) begin
    if (pld_valid && pld_ready) begin
      pld_len <= pld_len_in;
      pld_cks <= pld_cks_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      send_pld <= 1'b0;
      send_ack <= 1'b0;
      send_ka  <= 1'b0;
      loc_seq  <= init_seq;
      last_seq <= init_seq;
      ka_cnt   <= '0;
    end else begin
      if (pld_valid && pld_ready) send_pld <= 1'b1;
      if (pld_sent) begin
        send_pld <= 1'b0;
        loc_seq  <= loc_seq + tcp_num_t'(pld_len);
        last_seq <= loc_seq + tcp_num_t'(pld_len);  // next byte to send
      end
      if (ack_sent) send_ack <= 1'b0;
      if (ack_req)  send_ack <= 1'b1;  // new request wins over a clear
      if (ka_sent)  send_ka  <= 1'b0;
      if (!tx_idle) begin
        ka_cnt <= '0;
      end else if (ka_cnt == KA_CNT_W'(KA_TIMEOUT - 1)) begin
        ka_cnt  <= '0;
        send_ka <= 1'b1;
      end else begin
        ka_cnt <= ka_cnt + 1'b1;
      end
    end
  end

  // the arbiter answers only requests still held here
  assert property (@(posedge clk) disable iff (rst)
    (pld_sent |-> send_pld) and (ka_sent |-> send_ka) and (ack_sent |-> send_ack))
    else $error("sent pulse without a pending request");

endmodule

// ==== source/tcp_tx_pkg.sv ====
package tcp_tx_pkg;

  localparam logic [3:0]  TCP_DEFAULT_OFFSET  = 4'd5;   // 20-byte header, no options
  localparam logic [15:0] DEFAULT_WINDOW_SIZE = 16'd1000;
  localparam logic [7:0]  DEFAULT_TTL         = 8'd64;
  localparam logic [7:0]  PROTO_TCP           = 8'd6;

  // flag field is ns cwr ece urg ack psh rst syn fin
  localparam logic [8:0]  TCP_FLAG_ACK = 9'h010;
  localparam logic [8:0]  TCP_FLAG_PSH = 9'h008;

  localparam int HDR_WORDS  = 10;
  localparam int KA_TIMEOUT = 2000;  // idle cycles before a keep-alive
  localparam int KA_CNT_W   = $clog2(KA_TIMEOUT);

  typedef logic [3:0][7:0] ipv4_addr_t;
  typedef logic [15:0]     port_t;
  typedef logic [31:0]     tcp_num_t;

  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] length;
    logic [15:0] id;
    logic        zero;
    logic        df;
    logic        mf;
    logic [12:0] fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] cks;
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    port_t       src_port;
    port_t       dst_port;
    tcp_num_t    tcp_seq_num;
    tcp_num_t    tcp_ack_num;
    logic [3:0]  tcp_offset;
    logic [2:0]  reserved;
    logic [8:0]  tcp_flags;
    logic [15:0] tcp_wnd_size;
    logic [15:0] tcp_cks;
    logic [15:0] tcp_pointer;
  } tcp_hdr_t;

  typedef struct packed {
    ipv4_hdr_t   ipv4_hdr;
    tcp_hdr_t    tcp_hdr;
    logic [15:0] pld_len;
    logic [15:0] pld_cks;
  } tcp_meta_t;

  typedef struct packed {
    port_t      loc_port;
    port_t      rem_port;
    ipv4_addr_t ipv4_addr;  // remote host
    tcp_num_t   loc_ack;
  } tcb_t;

  typedef enum logic [1:0] {
    tcp_closed,
    tcp_connecting,
    tcp_connected,
    tcp_closing
  } tcp_stat_t;

  typedef enum logic [3:0] {
    tx_none = 4'b0001,
    tx_ka   = 4'b0010,
    tx_ack  = 4'b0100,
    tx_pld  = 4'b1000
  } tx_type_t;

endpackage
